// File: common/axi_lite_regs_macros.svh
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite register bank constants
// Register count, bus and register widths, the read-only mask and the
// pattern returned for reads outside the register window.
////////////////////////////////////////////////////////////////////////////

`ifndef AXI_LITE_REGS_MACROS_SVH
`define AXI_LITE_REGS_MACROS_SVH

// Number of registers mapped onto the bus
`define AXI_LITE_REGS_NUM_REGS 8

// Bus address width in bits
`define AXI_LITE_REGS_ADDR_WIDTH 16

// Bus data width in bits, also sets the register stride in bytes
`define AXI_LITE_REGS_DATA_WIDTH 32

// Width of one register, zero-extended on reads
`define AXI_LITE_REGS_REG_WIDTH 24

// One bit per register, a set bit passes reg_d_i through and refuses writes
`define AXI_LITE_REGS_READ_ONLY 8'hC0

// Read data returned with a slave error outside the window
`define AXI_LITE_REGS_ERR_DATA 32'hBA5E1E55

`endif

// File: common/axi_lite_pkg.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite bus types
// Address, data, strobe and response types plus the B and R payloads.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "axi_lite_regs_macros.svh"

package axi_lite_pkg;

  // Byte address on the AW and AR channels
  typedef logic [`AXI_LITE_REGS_ADDR_WIDTH-1:0] addr_t;

  // Write and read data word
  typedef logic [`AXI_LITE_REGS_DATA_WIDTH-1:0] data_t;

  // One strobe bit per data byte
  typedef logic [`AXI_LITE_REGS_DATA_WIDTH/8-1:0] strb_t;

  // Response codes, only OKAY and SLVERR are produced by this slave
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  // Write response payload
  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  // Read response payload
  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

endpackage

`default_nettype wire

// File: common/regs_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Register bank types
// Register value, register index and the packed register array.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "axi_lite_regs_macros.svh"

package regs_pkg;

  // Value held by one register
  typedef logic [`AXI_LITE_REGS_REG_WIDTH-1:0] reg_data_t;

  // Index wide enough to select any register
  typedef logic [$clog2(`AXI_LITE_REGS_NUM_REGS)-1:0] reg_idx_t;

  // All registers side by side, index 0 in the lowest bits
  typedef reg_data_t [`AXI_LITE_REGS_NUM_REGS-1:0] reg_array_t;

endpackage

`default_nettype wire

// File: src/spill_register.sv
////////////////////////////////////////////////////////////////////////////
// Two-entry spill register
// Valid/ready buffer that cuts every combinational path between its input
// and output sides. The payload type is a parameter.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot A takes new items, slot B holds the older item when the output stalls
  logic a_full_q;
  T     a_data_q;
  logic b_full_q;
  T     b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // Accept whenever a slot is free, this only looks at local state
  assign ready_o = ~a_full_q | ~b_full_q;

  // An item enters slot A on an input handshake
  assign a_fill = valid_i & ready_o;

  // Slot A empties when B is free, it either leaves or moves into B
  assign a_drain = a_full_q & ~b_full_q;

  // The item from A moves into B only when the output is stalled
  assign b_fill = a_drain & ~ready_i;

  // Slot B empties on an output handshake
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
    end else if (a_fill || a_drain) begin
      a_full_q <= a_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_full_q <= 1'b0;
    end else if (b_fill || b_drain) begin
      b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // B always holds the older item, so it leaves first
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

// File: axi_lite_regs/reg_addr_decode.sv
////////////////////////////////////////////////////////////////////////////
// Register address decoder
// Maps a bus byte address onto a register index relative to a base.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_regs_macros.svh"

module reg_addr_decode (
  input  axi_lite_pkg::addr_t addr_i,
  input  axi_lite_pkg::addr_t base_addr_i,
  output regs_pkg::reg_idx_t  idx_o,
  output logic                hit_o
);

  // Each register occupies one full bus word
  localparam int unsigned stride = `AXI_LITE_REGS_DATA_WIDTH / 8;
  localparam int unsigned window = `AXI_LITE_REGS_NUM_REGS * stride;

  axi_lite_pkg::addr_t offset;

  // Offset from the base, only meaningful when the address is not below it
  assign offset = addr_i - base_addr_i;

  // Comparing the offset avoids an overflow of base plus window
  assign hit_o = (addr_i >= base_addr_i) && (offset < window);

  // Any byte within a word selects the same register
  assign idx_o = regs_pkg::reg_idx_t'(offset / stride);

endmodule

`default_nettype wire

// File: axi_lite_regs/reg_write_stage.sv
////////////////////////////////////////////////////////////////////////////
// Register write stage
// Holds the register array, applies external loads and strobed bus writes,
// and forms the write response for the B spill register.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_regs_macros.svh"

module reg_write_stage (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                aw_valid_i,
  input  logic                                w_valid_i,
  input  axi_lite_pkg::data_t                 w_data_i,
  input  axi_lite_pkg::strb_t                 w_strb_i,
  input  regs_pkg::reg_idx_t                  aw_idx_i,
  input  logic                                aw_hit_i,
  input  regs_pkg::reg_array_t                reg_d_i,
  input  logic [`AXI_LITE_REGS_NUM_REGS-1:0]  reg_load_i,
  output logic                                aw_ready_o,
  output logic                                w_ready_o,
  output axi_lite_pkg::b_chan_t               b_chan_o,
  output logic                                b_valid_o,
  input  logic                                b_ready_i,
  output regs_pkg::reg_array_t                reg_q_o
);

  localparam int unsigned num_regs  = `AXI_LITE_REGS_NUM_REGS;
  localparam int unsigned reg_width = `AXI_LITE_REGS_REG_WIDTH;
  localparam logic [num_regs-1:0] read_only = `AXI_LITE_REGS_READ_ONLY;

  regs_pkg::reg_array_t reg_q;
  regs_pkg::reg_array_t reg_next;
  logic [num_regs-1:0]  reg_update;
  logic                 has_reset_q;
  logic                 write_fire;

  // Both write channels must be valid together, and the B buffer must have room
  assign write_fire = aw_valid_i & w_valid_i & b_ready_i;

  always_comb begin
    reg_next   = reg_q;
    reg_update = '0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
    b_chan_o   = '{resp: axi_lite_pkg::RESP_SLVERR};

    // External loads go first
    // Right after reset every writable register takes its external value
    for (int unsigned i = 0; i < num_regs; i++) begin
      if ((reg_load_i[i] || !has_reset_q) && !read_only[i]) begin
        reg_next[i]   = reg_d_i[i];
        reg_update[i] = 1'b1;
      end
    end

    if (write_fire) begin
      // Every accepted write produces exactly one response
      aw_ready_o = 1'b1;
      w_ready_o  = 1'b1;
      b_valid_o  = 1'b1;

      // A pending load on the target wins over the bus write
      if (aw_hit_i && !read_only[aw_idx_i] && !reg_update[aw_idx_i]) begin
        b_chan_o.resp = axi_lite_pkg::RESP_OKAY;
        // Merge enabled byte lanes and let bus bits above the register width fall away
        for (int unsigned b = 0; b < reg_width; b++) begin
          if (w_strb_i[b/8]) begin
            reg_next[aw_idx_i][b] = w_data_i[b];
          end
        end
        reg_update[aw_idx_i] = 1'b1;
      end
    end
  end

  // Low only in the first cycle after reset is released
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      has_reset_q <= 1'b0;
    end else begin
      has_reset_q <= 1'b1;
    end
  end

  // Each register takes its next value only in a cycle where it is updated
  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < num_regs; i++) begin
      if (reg_update[i]) begin
        reg_q[i] <= reg_next[i];
      end
    end
  end

  // Read-only slots show the external value without a register stage
  for (genvar g = 0; g < num_regs; g++) begin : gen_reg_out
    assign reg_q_o[g] = read_only[g] ? reg_d_i[g] : reg_q[g];
  end

endmodule

`default_nettype wire

// File: axi_lite_regs/reg_read_stage.sv
////////////////////////////////////////////////////////////////////////////
// Register read stage
// Selects the addressed register and forms the read response.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_regs_macros.svh"

module reg_read_stage (
  input  regs_pkg::reg_idx_t    ar_idx_i,
  input  logic                  ar_hit_i,
  input  regs_pkg::reg_array_t  reg_q_i,
  output axi_lite_pkg::r_chan_t r_chan_o
);

  regs_pkg::reg_data_t sel_data;

  // Read-only slots already carry the external value on reg_q_i
  assign sel_data = reg_q_i[ar_idx_i];

  always_comb begin
    if (ar_hit_i) begin
      // Zero extension to the bus width leaves the top byte clear
      r_chan_o.data = axi_lite_pkg::data_t'(sel_data);
      r_chan_o.resp = axi_lite_pkg::RESP_OKAY;
    end else begin
      // Outside the window, a fixed pattern makes the error easy to spot
      r_chan_o.data = `AXI_LITE_REGS_ERR_DATA;
      r_chan_o.resp = axi_lite_pkg::RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

// File: axi_lite_regs/axi_lite_regs.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite control register bank
// Eight 24-bit registers behind an AXI4-Lite slave port, with external
// loads, read-only pass-through and registered B and R responses.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_regs_macros.svh"

module axi_lite_regs (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  axi_lite_pkg::addr_t                aw_addr_i,
  input  logic                               aw_valid_i,
  output logic                               aw_ready_o,
  input  axi_lite_pkg::data_t                w_data_i,
  input  axi_lite_pkg::strb_t                w_strb_i,
  input  logic                               w_valid_i,
  output logic                               w_ready_o,
  output axi_lite_pkg::resp_t                b_resp_o,
  output logic                               b_valid_o,
  input  logic                               b_ready_i,
  input  axi_lite_pkg::addr_t                ar_addr_i,
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  output axi_lite_pkg::data_t                r_data_o,
  output axi_lite_pkg::resp_t                r_resp_o,
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  input  axi_lite_pkg::addr_t                base_addr_i,
  input  regs_pkg::reg_array_t               reg_d_i,
  input  logic [`AXI_LITE_REGS_NUM_REGS-1:0] reg_load_i,
  output regs_pkg::reg_array_t               reg_q_o
);

  regs_pkg::reg_idx_t    aw_idx;
  logic                  aw_hit;
  regs_pkg::reg_idx_t    ar_idx;
  logic                  ar_hit;
  axi_lite_pkg::b_chan_t b_chan;
  logic                  b_valid;
  logic                  b_ready;
  axi_lite_pkg::b_chan_t b_chan_out;
  axi_lite_pkg::r_chan_t r_chan;
  axi_lite_pkg::r_chan_t r_chan_out;

  reg_addr_decode u_aw_decode (
    .addr_i      (aw_addr_i),
    .base_addr_i (base_addr_i),
    .idx_o       (aw_idx),
    .hit_o       (aw_hit)
  );

  reg_addr_decode u_ar_decode (
    .addr_i      (ar_addr_i),
    .base_addr_i (base_addr_i),
    .idx_o       (ar_idx),
    .hit_o       (ar_hit)
  );

  reg_write_stage u_write_stage (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .aw_valid_i (aw_valid_i),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .aw_idx_i   (aw_idx),
    .aw_hit_i   (aw_hit),
    .reg_d_i    (reg_d_i),
    .reg_load_i (reg_load_i),
    .aw_ready_o (aw_ready_o),
    .w_ready_o  (w_ready_o),
    .b_chan_o   (b_chan),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .reg_q_o    (reg_q_o)
  );

  reg_read_stage u_read_stage (
    .ar_idx_i (ar_idx),
    .ar_hit_i (ar_hit),
    .reg_q_i  (reg_q_o),
    .r_chan_o (r_chan)
  );

  // Registered B response, the port outputs never see the request inputs
  spill_register #(
    .T (axi_lite_pkg::b_chan_t)
  ) u_b_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (b_valid),
    .ready_o (b_ready),
    .data_i  (b_chan),
    .valid_o (b_valid_o),
    .ready_i (b_ready_i),
    .data_o  (b_chan_out)
  );

  // AR is accepted exactly when the R buffer has room
  spill_register #(
    .T (axi_lite_pkg::r_chan_t)
  ) u_r_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (ar_valid_i),
    .ready_o (ar_ready_o),
    .data_i  (r_chan),
    .valid_o (r_valid_o),
    .ready_i (r_ready_i),
    .data_o  (r_chan_out)
  );

  assign b_resp_o = b_chan_out.resp;
  assign r_data_o = r_chan_out.data;
  assign r_resp_o = r_chan_out.resp;

endmodule

`default_nettype wire

// File: verif/tb_axi_lite_regs.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite register bank testbench
// Drives writes, reads and external loads, predicts every response with a
// reference model and compares the B and R beats in request order.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_regs_macros.svh"

module tb_axi_lite_regs;

  localparam int unsigned num_regs = `AXI_LITE_REGS_NUM_REGS;
  localparam logic [num_regs-1:0] ro_mask = 8'hC0;
  // Roughly 500 transactions of at most about 10 cycles each fit well inside this
  localparam int unsigned max_cycles = 20000;

  logic                         clk_i;
  logic                         reset_i;
  axi_lite_pkg::addr_t          aw_addr_i;
  logic                         aw_valid_i;
  logic                         aw_ready_o;
  axi_lite_pkg::data_t          w_data_i;
  axi_lite_pkg::strb_t          w_strb_i;
  logic                         w_valid_i;
  logic                         w_ready_o;
  axi_lite_pkg::resp_t          b_resp_o;
  logic                         b_valid_o;
  logic                         b_ready_i;
  axi_lite_pkg::addr_t          ar_addr_i;
  logic                         ar_valid_i;
  logic                         ar_ready_o;
  axi_lite_pkg::data_t          r_data_o;
  axi_lite_pkg::resp_t          r_resp_o;
  logic                         r_valid_o;
  logic                         r_ready_i;
  axi_lite_pkg::addr_t          base_addr_i;
  regs_pkg::reg_array_t         reg_d_i;
  logic [num_regs-1:0]          reg_load_i;
  regs_pkg::reg_array_t         reg_q_o;

  // Expected contents of the writable registers
  regs_pkg::reg_data_t  model_q [num_regs];
  axi_lite_pkg::resp_t  exp_b_q [$];
  axi_lite_pkg::resp_t  exp_r_resp_q [$];
  axi_lite_pkg::data_t  exp_r_data_q [$];
  logic                 stall_en = 1'b0;
  int unsigned          b_sent = 0;
  int unsigned          r_sent = 0;
  int unsigned          b_seen = 0;
  int unsigned          r_seen = 0;
  int unsigned          cycle_count = 0;

  axi_lite_regs uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("CHECKS FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_resp(input string name, input axi_lite_pkg::resp_t exp_val,
                            input axi_lite_pkg::resp_t act_val);
    if (act_val !== exp_val) begin
      $display("FAIL at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
      $display("CHECKS FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_data(input string name, input axi_lite_pkg::data_t exp_val,
                            input axi_lite_pkg::data_t act_val);
    if (act_val !== exp_val) begin
      $display("FAIL at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
      $display("CHECKS FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_reg(input string name, input regs_pkg::reg_data_t exp_val,
                           input regs_pkg::reg_data_t act_val);
    if (act_val !== exp_val) begin
      $display("FAIL at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
      $display("CHECKS FAILED");
      $fatal(1, "register mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("FAIL at %0t: %s expected %b actual %b", $time, name, exp_val, act_val);
      $display("CHECKS FAILED");
      $fatal(1, "handshake mismatch");
    end
  endtask

  // Window of eight words of 4 bytes starting at the base
  function automatic logic addr_hits(input axi_lite_pkg::addr_t addr);
    int unsigned lo;
    int unsigned hi;
    lo = base_addr_i;
    hi = lo + 32;
    return (addr >= lo) && (addr < hi);
  endfunction

  function automatic int unsigned addr_index(input axi_lite_pkg::addr_t addr);
    axi_lite_pkg::addr_t offset;
    offset = addr - base_addr_i;
    return offset >> 2;
  endfunction

  // A write is refused outside the window, on read-only slots and on a load collision
  function automatic axi_lite_pkg::resp_t predict_write_resp(input axi_lite_pkg::addr_t addr,
                                                             input logic [num_regs-1:0] load);
    int unsigned idx;
    idx = addr_index(addr);
    if (!addr_hits(addr) || ro_mask[idx] || load[idx]) begin
      return axi_lite_pkg::RESP_SLVERR;
    end
    return axi_lite_pkg::RESP_OKAY;
  endfunction

  // Only the three low byte lanes reach a 24-bit register
  function automatic regs_pkg::reg_data_t merge_write(input regs_pkg::reg_data_t old,
                                                      input axi_lite_pkg::data_t data,
                                                      input axi_lite_pkg::strb_t strb);
    regs_pkg::reg_data_t merged;
    merged = old;
    for (int lane = 0; lane < 3; lane++) begin
      if (strb[lane]) begin
        merged[lane*8 +: 8] = data[lane*8 +: 8];
      end
    end
    return merged;
  endfunction

  function automatic axi_lite_pkg::data_t predict_read(input axi_lite_pkg::addr_t addr);
    int unsigned idx;
    idx = addr_index(addr);
    if (!addr_hits(addr)) begin
      return 32'hBA5E1E55;
    end
    if (ro_mask[idx]) begin
      return {8'h00, reg_d_i[idx]};
    end
    return {8'h00, model_q[idx]};
  endfunction

  task automatic apply_loads(input logic [num_regs-1:0] load);
    for (int i = 0; i < num_regs; i++) begin
      if (load[i] && !ro_mask[i]) begin
        model_q[i] = reg_d_i[i];
      end
    end
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < num_regs; i++) begin
      check_reg($sformatf("reg_q_o[%0d]", i), ro_mask[i] ? reg_d_i[i] : model_q[i],
                reg_q_o[i]);
    end
  endtask

  task automatic issue_write(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
                             input axi_lite_pkg::strb_t strb, input logic [num_regs-1:0] load);
    logic                fire;
    axi_lite_pkg::resp_t resp;
    int unsigned         idx;
    idx = addr_index(addr);
    @(negedge clk_i);
    aw_addr_i  = addr;
    w_data_i   = data;
    w_strb_i   = strb;
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    reg_load_i = load;
    fire = 1'b0;
    while (!fire) begin
      // Ready settles shortly after the falling edge and holds until the rising edge
      #1;
      check_flag("w_ready_o", aw_ready_o, w_ready_o);
      fire = aw_ready_o & w_ready_o;
      resp = predict_write_resp(addr, load);
      @(posedge clk_i);
      apply_loads(load);
      if (fire) begin
        if (resp == axi_lite_pkg::RESP_OKAY) begin
          model_q[idx] = merge_write(model_q[idx], data, strb);
        end
        exp_b_q.push_back(resp);
        b_sent++;
      end else begin
        @(negedge clk_i);
      end
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    reg_load_i = '0;
    check_all_regs();
  endtask

  task automatic issue_read(input axi_lite_pkg::addr_t addr);
    logic                fire;
    axi_lite_pkg::data_t data;
    @(negedge clk_i);
    ar_addr_i  = addr;
    ar_valid_i = 1'b1;
    fire = 1'b0;
    while (!fire) begin
      #1;
      fire = ar_ready_o;
      data = predict_read(addr);
      @(posedge clk_i);
      if (fire) begin
        exp_r_data_q.push_back(data);
        exp_r_resp_q.push_back(addr_hits(addr) ? axi_lite_pkg::RESP_OKAY :
                               axi_lite_pkg::RESP_SLVERR);
        r_sent++;
      end else begin
        @(negedge clk_i);
      end
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    check_all_regs();
  endtask

  // The valids and payloads come from flops and are steady at the falling edge
  initial begin
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      // Under stall the ready is high one cycle in three so both spill slots fill up
      b_ready_i = stall_en ? ($urandom % 3 == 0) : 1'b1;
      r_ready_i = stall_en ? ($urandom % 3 == 0) : 1'b1;
      if (b_valid_o === 1'b1 && b_ready_i) begin
        if (exp_b_q.size() == 0) begin
          $display("A write response arrived with no write outstanding");
          $display("CHECKS FAILED");
          $fatal(1, "unexpected B beat");
        end else begin
          check_resp("b_resp_o", exp_b_q.pop_front(), b_resp_o);
          b_seen++;
        end
      end
      if (r_valid_o === 1'b1 && r_ready_i) begin
        if (exp_r_resp_q.size() == 0) begin
          $display("A read response arrived with no read outstanding");
          $display("CHECKS FAILED");
          $fatal(1, "unexpected R beat");
        end else begin
          check_resp("r_resp_o", exp_r_resp_q.pop_front(), r_resp_o);
          check_data("r_data_o", exp_r_data_q.pop_front(), r_data_o);
          r_seen++;
        end
      end
    end
  end

  initial begin
    int unsigned              seed_val;
    int unsigned              idx;
    int unsigned              other;
    axi_lite_pkg::addr_t      addr;
    logic [num_regs-1:0]      load;
    seed_val = $urandom(57767);
    reset_i     = 1'b1;
    aw_addr_i   = '0;
    aw_valid_i  = 1'b0;
    w_data_i    = '0;
    w_strb_i    = '0;
    w_valid_i   = 1'b0;
    ar_addr_i   = '0;
    ar_valid_i  = 1'b0;
    base_addr_i = '0;
    reg_load_i  = '0;
    for (int i = 0; i < num_regs; i++) begin
      reg_d_i[i] = regs_pkg::reg_data_t'($urandom);
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    // Only the value present in the first cycle after reset may stick
    for (int i = 0; i < num_regs; i++) begin
      reg_d_i[i] = regs_pkg::reg_data_t'($urandom);
    end
    // The first edge after reset copies reg_d_i into every writable register
    @(posedge clk_i);
    apply_loads('1);
    @(negedge clk_i);
    check_flag("b_valid_o", 1'b0, b_valid_o);
    check_flag("r_valid_o", 1'b0, r_valid_o);
    check_flag("aw_ready_o", 1'b0, aw_ready_o);
    check_flag("w_ready_o", 1'b0, w_ready_o);
    check_flag("ar_ready_o", 1'b1, ar_ready_o);
    check_all_regs();
    // Writable registers hold while the read-only ones follow the new inputs
    for (int i = 0; i < num_regs; i++) begin
      reg_d_i[i] = regs_pkg::reg_data_t'($urandom);
    end
    @(negedge clk_i);
    check_all_regs();
    for (int i = 0; i < num_regs; i++) begin
      issue_read(base_addr_i + 4 * i);
    end

    // Strobed writes at any byte of a word with a read-back after each
    repeat (80) begin
      idx  = $urandom % 6;
      addr = base_addr_i + 4 * idx + ($urandom % 4);
      issue_write(addr, $urandom, $urandom, '0);
      issue_read(base_addr_i + 4 * idx);
    end

    // Read-only slots refuse writes and follow reg_d_i
    repeat (10) begin
      idx = 6 + $urandom % 2;
      issue_write(base_addr_i + 4 * idx, $urandom, 4'hF, '0);
      reg_d_i[idx] = regs_pkg::reg_data_t'($urandom);
      issue_read(base_addr_i + 4 * idx);
    end

    // Accesses below the base and past the window
    base_addr_i = 16'h4A00;
    repeat (40) begin
      if ($urandom % 2) begin
        addr = base_addr_i - 1 - ($urandom % 64);
      end else begin
        addr = base_addr_i + 32 + ($urandom % 64);
      end
      issue_write(addr, $urandom, 4'hF, '0);
      issue_read(addr);
    end

    // A load on the target wins over the write while a load elsewhere leaves it alone
    repeat (20) begin
      idx = $urandom % 6;
      reg_d_i[idx] = regs_pkg::reg_data_t'($urandom);
      issue_write(base_addr_i + 4 * idx, $urandom, 4'hF, num_regs'(1) << idx);
      issue_read(base_addr_i + 4 * idx);
      other = (idx + 1 + $urandom % 5) % 6;
      reg_d_i[other] = regs_pkg::reg_data_t'($urandom);
      issue_write(base_addr_i + 4 * idx, $urandom, $urandom, num_regs'(1) << other);
      issue_read(base_addr_i + 4 * idx);
      issue_read(base_addr_i + 4 * other);
    end

    // Mixed burst with random stalls on both response channels
    stall_en = 1'b1;
    repeat (150) begin
      if ($urandom % 4 == 0) begin
        reg_d_i[$urandom % num_regs] = regs_pkg::reg_data_t'($urandom);
      end
      addr = base_addr_i - 8 + ($urandom % 48);
      load = ($urandom % 4 == 0) ? (num_regs'(1) << ($urandom % num_regs)) : '0;
      if ($urandom % 2) begin
        issue_write(addr, $urandom, $urandom, load);
      end else begin
        issue_read(addr);
      end
    end
    stall_en = 1'b0;

    while (b_seen != b_sent || r_seen != r_sent) begin
      @(negedge clk_i);
    end
    // A few idle cycles give any stray beat time to reach the response checker
    repeat (4) @(negedge clk_i);
    check_flag("b_valid_o", 1'b0, b_valid_o);
    check_flag("r_valid_o", 1'b0, r_valid_o);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/axi_lite_pkg.sv
common/regs_pkg.sv
src/spill_register.sv
axi_lite_regs/reg_addr_decode.sv
axi_lite_regs/reg_write_stage.sv
axi_lite_regs/reg_read_stage.sv
axi_lite_regs/axi_lite_regs.sv
verif/tb_axi_lite_regs.sv

// File: Bender.yml
package:
  name: axi_lite_regs

export_include_dirs:
  - common

sources:
  # Packages first, then the leaf blocks, then the top level
  - include_dirs:
      - common
    files:
      - common/axi_lite_pkg.sv
      - common/regs_pkg.sv
      - src/spill_register.sv
      - axi_lite_regs/reg_addr_decode.sv
      - axi_lite_regs/reg_write_stage.sv
      - axi_lite_regs/reg_read_stage.sv
      - axi_lite_regs/axi_lite_regs.sv

  # Self-checking testbench
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_axi_lite_regs.sv
